/* verilog/rsp_order_pkg.sv */
// Widths and depths shared by the response-ordering shim; depth must be a power of two
package rsp_order_pkg;

    // ==============================
    // Buffer sizing
    // ==============================

    // Requests that may be in flight on one channel at a time.
    // Both the read reorder buffer and the write mdata heap hold this many slots
    localparam int MAX_ACTIVE_REQS = 16;

    // Bits needed to name one slot
    localparam int REQ_IDX_WIDTH = $clog2(MAX_ACTIVE_REQS);

    // Requests the AFU may still issue after it samples almost-full.
    // A channel block raises not-ready once its free slots drop to this
    // many, so the slack always fits in what is left
    localparam int ALMOST_FULL_SLACK = 4;

    // ==============================
    // Field widths
    // ==============================

    // AFU metadata tag carried by every request and echoed by the fabric
    localparam int MDATA_WIDTH = 16;

    // Line address of a request
    localparam int ADDR_WIDTH = 16;

    // Payload of a write request or a read response
    localparam int DATA_WIDTH = 32;

    // ==============================
    // Shared types
    // ==============================

    typedef logic [MDATA_WIDTH-1:0] t_mdata;
    typedef logic [ADDR_WIDTH-1:0] t_addr;
    typedef logic [DATA_WIDTH-1:0] t_data;

    // Slot index, placed in the low bits of mdata toward the fabric
    typedef logic [REQ_IDX_WIDTH-1:0] t_req_idx;

    // Slot counter, one bit wider than an index so that a completely
    // free buffer (MAX_ACTIVE_REQS) can be represented
    typedef logic [REQ_IDX_WIDTH:0] t_slot_cnt;

    // Free-slot count at or below which a channel block reports not-ready
    localparam t_slot_cnt NOT_READY_LIMIT = t_slot_cnt'(ALMOST_FULL_SLACK);

endpackage

/* verilog/slot_ram.sv */
// Slot memory with one write and one registered read per cycle; contents are undefined after reset
module slot_ram
    import rsp_order_pkg::*;
#(
    // Payload held in each slot, read data or a saved mdata tag
    parameter type t_payload = t_data
)
(
    input  logic     clk,

    // Write port, used when a slot is filled
    input  logic     wr_en,
    input  t_req_idx wr_idx,
    input  t_payload wr_payload,

    // Read port, the payload shows up one cycle after rd_idx
    input  t_req_idx rd_idx,
    output t_payload rd_payload
);

    // One entry per slot that the owning block can allocate
    t_payload mem [MAX_ACTIVE_REQS];

    // Writes land at the clock edge
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_payload;
        end
    end

    // The read is registered, which maps onto block RAM output registers.
    // A read and a write to the same slot in one cycle return the old value
    always_ff @(posedge clk)
    begin
        rd_payload <= mem[rd_idx];
    end

endmodule

/* verilog/wr_mdata_heap.sv */
// Write mdata heap; callers must honor not_ready with the package slack and never free an idle slot
module wr_mdata_heap
    import rsp_order_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Allocation side, driven by write requests from the AFU
    input  logic     alloc,
    input  t_mdata   alloc_mdata,
    output t_req_idx alloc_idx,
    output logic     not_ready,

    // Release side, driven by write responses from the fabric
    input  logic     free,
    input  t_req_idx free_idx,
    output t_mdata   restored_mdata
);

    // ==============================
    // Free list
    // ==============================

    // Circular FIFO of slot indexes that are not in use.
    // After reset it holds every index, oldest first
    t_req_idx free_list [MAX_ACTIVE_REQS];

    // Head names the next index handed out, tail the place where a freed one goes.
    // Both wrap on their own because the depth is a power of two
    t_req_idx head_ptr;
    t_req_idx tail_ptr;

    // Number of indexes currently in the free list
    t_slot_cnt free_cnt;
    t_slot_cnt free_cnt_next;

    // The next free index is offered before the request arrives, so the
    // tag substitution costs no cycle
    assign alloc_idx = free_list[head_ptr];

    // Allocation and release may happen in the same cycle
    assign free_cnt_next = free_cnt - t_slot_cnt'(alloc) + t_slot_cnt'(free);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < MAX_ACTIVE_REQS; i++)
            begin
                free_list[i] <= t_req_idx'(i);
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            free_cnt <= t_slot_cnt'(MAX_ACTIVE_REQS);
            not_ready <= 1'b0;
        end
        else
        begin
            if (alloc)
            begin
                head_ptr <= head_ptr + 1'b1;
            end

            // A freed index goes to the back so slots are reused round-robin
            if (free)
            begin
                free_list[tail_ptr] <= free_idx;
                tail_ptr <= tail_ptr + 1'b1;
            end

            free_cnt <= free_cnt_next;

            // Raised from the updated count so the AFU sees it in the very
            // next cycle and its remaining slack still fits
            not_ready <= (free_cnt_next <= NOT_READY_LIMIT);
        end
    end

    // ==============================
    // Saved mdata
    // ==============================

    // The original tag is stored at the slot index sent to the fabric.
    // On a response the echoed index reads it back one cycle later
    slot_ram #(
        .t_payload(t_mdata)
    ) mdata_ram (
        .clk,
        .wr_en(alloc),
        .wr_idx(alloc_idx),
        .wr_payload(alloc_mdata),
        .rd_idx(free_idx),
        .rd_payload(restored_mdata)
    );

endmodule

/* verilog/rd_reorder_buffer.sv */
// Read reorder buffer; one response per slot, callers honor not_ready, output cannot be stalled
module rd_reorder_buffer
    import rsp_order_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Allocation side, one slot per AFU read request
    input  logic     alloc,
    input  t_mdata   alloc_mdata,
    output t_req_idx alloc_idx,
    output logic     not_ready,

    // Responses from the fabric, tagged with the slot index, in any order
    input  logic     rsp_valid,
    input  t_req_idx rsp_idx,
    input  t_data    rsp_data,

    // Responses to the AFU, in request order
    output logic     out_valid,
    output t_mdata   out_mdata,
    output t_data    out_data
);

    // ==============================
    // Slot bookkeeping
    // ==============================

    // Slots are allocated at the tail and retired at the head, in order
    t_req_idx head_ptr;
    t_req_idx tail_ptr;

    // One bit per slot, set once the response for that slot has arrived
    logic [MAX_ACTIVE_REQS-1:0] filled;
    logic [MAX_ACTIVE_REQS-1:0] filled_next;

    // Slots not yet handed out or already retired
    t_slot_cnt free_cnt;
    t_slot_cnt free_cnt_next;

    // The oldest request has its data and can leave this cycle
    logic release_head;

    // Release is in flight through the registered memory read
    logic pending;

    assign alloc_idx = tail_ptr;
    assign release_head = filled[head_ptr];

    // A response never targets the head slot while it is being released,
    // so setting and clearing never touch the same bit in one cycle
    always_comb
    begin
        filled_next = filled;
        if (rsp_valid)
        begin
            filled_next[rsp_idx] = 1'b1;
        end
        if (release_head)
        begin
            filled_next[head_ptr] = 1'b0;
        end
    end

    // A slot only comes back when it leaves the head
    assign free_cnt_next = free_cnt - t_slot_cnt'(alloc) + t_slot_cnt'(release_head);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            filled <= '0;
            free_cnt <= t_slot_cnt'(MAX_ACTIVE_REQS);
            not_ready <= 1'b0;
            pending <= 1'b0;
        end
        else
        begin
            if (alloc)
            begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (release_head)
            begin
                head_ptr <= head_ptr + 1'b1;
            end
            filled <= filled_next;
            free_cnt <= free_cnt_next;

            // Same threshold rule as the write heap
            not_ready <= (free_cnt_next <= NOT_READY_LIMIT);

            // Valid follows the memory read by one cycle
            pending <= release_head;
        end
    end

    assign out_valid = pending;

    // ==============================
    // Slot memories
    // ==============================

    // Response data is written by index when it arrives.
    // The head slot is read every cycle and only used when pending is set
    slot_ram #(
        .t_payload(t_data)
    ) data_ram (
        .clk,
        .wr_en(rsp_valid),
        .wr_idx(rsp_idx),
        .wr_payload(rsp_data),
        .rd_idx(head_ptr),
        .rd_payload(out_data)
    );

    // Original request mdata, saved at allocation and restored on release
    slot_ram #(
        .t_payload(t_mdata)
    ) mdata_ram (
        .clk,
        .wr_en(alloc),
        .wr_idx(tail_ptr),
        .wr_payload(alloc_mdata),
        .rd_idx(head_ptr),
        .rd_payload(out_mdata)
    );

endmodule

/* verilog/rsp_order_shim.sv */
// Response-ordering shim; the fabric must echo request mdata and the AFU must honor almost-full
module rsp_order_shim
    import rsp_order_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // Read requests from the AFU and toward the fabric
    input  logic   afu_rd_req_valid,
    input  t_addr  afu_rd_req_addr,
    input  t_mdata afu_rd_req_mdata,
    output logic   fiu_rd_req_valid,
    output t_addr  fiu_rd_req_addr,
    output t_mdata fiu_rd_req_mdata,

    // Write requests from the AFU and toward the fabric
    input  logic   afu_wr_req_valid,
    input  t_addr  afu_wr_req_addr,
    input  t_data  afu_wr_req_data,
    input  t_mdata afu_wr_req_mdata,
    output logic   fiu_wr_req_valid,
    output t_addr  fiu_wr_req_addr,
    output t_data  fiu_wr_req_data,
    output t_mdata fiu_wr_req_mdata,

    // Responses from the fabric, possibly out of order
    input  logic   fiu_rd_rsp_valid,
    input  t_mdata fiu_rd_rsp_mdata,
    input  t_data  fiu_rd_rsp_data,
    input  logic   fiu_wr_rsp_valid,
    input  t_mdata fiu_wr_rsp_mdata,

    // Responses to the AFU, reads in request order
    output logic   afu_rd_rsp_valid,
    output t_mdata afu_rd_rsp_mdata,
    output t_data  afu_rd_rsp_data,
    output logic   afu_wr_rsp_valid,
    output t_mdata afu_wr_rsp_mdata,

    // Flow control
    input  logic   fiu_rd_almost_full,
    input  logic   fiu_wr_almost_full,
    output logic   afu_rd_almost_full,
    output logic   afu_wr_almost_full
);

    t_req_idx rd_alloc_idx;
    t_req_idx wr_alloc_idx;
    logic     rd_not_ready;
    logic     wr_not_ready;

    // Write response valid, delayed to line up with the heap read
    logic     wr_rsp_valid_q;

    // ==============================
    // Read channel
    // ==============================

    // Requests pass straight through with the reorder slot in place of mdata
    assign fiu_rd_req_valid = afu_rd_req_valid;
    assign fiu_rd_req_addr = afu_rd_req_addr;
    assign fiu_rd_req_mdata = t_mdata'(rd_alloc_idx);

    // Only the low bits of the echoed tag carry the slot index
    rd_reorder_buffer rd_rob (
        .clk,
        .reset,
        .alloc(afu_rd_req_valid),
        .alloc_mdata(afu_rd_req_mdata),
        .alloc_idx(rd_alloc_idx),
        .not_ready(rd_not_ready),
        .rsp_valid(fiu_rd_rsp_valid),
        .rsp_idx(t_req_idx'(fiu_rd_rsp_mdata)),
        .rsp_data(fiu_rd_rsp_data),
        .out_valid(afu_rd_rsp_valid),
        .out_mdata(afu_rd_rsp_mdata),
        .out_data(afu_rd_rsp_data)
    );

    assign afu_rd_almost_full = fiu_rd_almost_full | rd_not_ready;

    // ==============================
    // Write channel
    // ==============================

    // Same substitution, using the heap slot that keeps the tag
    assign fiu_wr_req_valid = afu_wr_req_valid;
    assign fiu_wr_req_addr = afu_wr_req_addr;
    assign fiu_wr_req_data = afu_wr_req_data;
    assign fiu_wr_req_mdata = t_mdata'(wr_alloc_idx);

    wr_mdata_heap wr_heap (
        .clk,
        .reset,
        .alloc(afu_wr_req_valid),
        .alloc_mdata(afu_wr_req_mdata),
        .alloc_idx(wr_alloc_idx),
        .not_ready(wr_not_ready),
        .free(fiu_wr_rsp_valid),
        .free_idx(t_req_idx'(fiu_wr_rsp_mdata)),
        .restored_mdata(afu_wr_rsp_mdata)
    );

    // Write responses leave in arrival order, one cycle late
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_rsp_valid_q <= 1'b0;
        end
        else
        begin
            wr_rsp_valid_q <= fiu_wr_rsp_valid;
        end
    end

    assign afu_wr_rsp_valid = wr_rsp_valid_q;
    assign afu_wr_almost_full = fiu_wr_almost_full | wr_not_ready;

endmodule

/* verif/fiu_model.sv */
// Fabric model for simulation only; queue depth is unbounded and write payloads are not stored
module fiu_model
    import rsp_order_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // Test controls
    input  logic   hold_rsp,
    input  logic   raise_rd_af,
    input  logic   raise_wr_af,

    // Requests from the shim, mdata carries a slot index
    input  logic   rd_req_valid,
    input  t_addr  rd_req_addr,
    input  t_mdata rd_req_mdata,
    input  logic   wr_req_valid,
    input  t_mdata wr_req_mdata,

    // Responses back to the shim, at most one per channel per cycle
    output logic   rd_rsp_valid,
    output t_mdata rd_rsp_mdata,
    output t_data  rd_rsp_data,
    output logic   wr_rsp_valid,
    output t_mdata wr_rsp_mdata,
    output logic   rd_almost_full,
    output logic   wr_almost_full
);

    integer seed = 32'h02fa05ea;

    // Local cycle count, used to time each queued answer
    int cycle;

    // Pending answers, one entry per accepted request
    t_mdata rd_pend_mdata [$];
    t_data  rd_pend_data [$];
    int     rd_pend_due [$];
    t_mdata wr_pend_mdata [$];
    int     wr_pend_due [$];

    // Memory contents: upper half is address xor 5ac3, lower half is address plus 0f1d
    function automatic t_data mem_word(input t_addr addr);
        return {addr ^ 16'h5ac3, addr + 16'h0f1d};
    endfunction

    // Random answer delay of 1 to 12 cycles
    function automatic int pick_delay();
        return int'(($random(seed) & 32'h7fffffff) % 12) + 1;
    endfunction

    // Almost-full only moves when a test asks for it
    assign rd_almost_full = raise_rd_af;
    assign wr_almost_full = raise_wr_af;

    initial
    begin
        rd_rsp_valid = 1'b0;
        rd_rsp_mdata = '0;
        rd_rsp_data = '0;
        wr_rsp_valid = 1'b0;
        wr_rsp_mdata = '0;
    end

    always @(posedge clk)
    begin
        int rd_pick;
        int wr_pick;
        rd_pick = -1;
        wr_pick = -1;
        rd_rsp_valid <= 1'b0;
        wr_rsp_valid <= 1'b0;
        if (reset)
        begin
            cycle = 0;
            rd_pend_mdata.delete();
            rd_pend_data.delete();
            rd_pend_due.delete();
            wr_pend_mdata.delete();
            wr_pend_due.delete();
        end
        else
        begin
            cycle = cycle + 1;
            // The first expired entry wins, so answers leave out of request order
            if (!hold_rsp)
            begin
                for (int i = 0; i < rd_pend_due.size(); i++)
                begin
                    if (rd_pick < 0 && rd_pend_due[i] <= cycle)
                    begin
                        rd_pick = i;
                    end
                end
                for (int i = 0; i < wr_pend_due.size(); i++)
                begin
                    if (wr_pick < 0 && wr_pend_due[i] <= cycle)
                    begin
                        wr_pick = i;
                    end
                end
            end
            if (rd_pick >= 0)
            begin
                rd_rsp_valid <= 1'b1;
                rd_rsp_mdata <= rd_pend_mdata[rd_pick];
                rd_rsp_data <= rd_pend_data[rd_pick];
                rd_pend_mdata.delete(rd_pick);
                rd_pend_data.delete(rd_pick);
                rd_pend_due.delete(rd_pick);
            end
            if (wr_pick >= 0)
            begin
                wr_rsp_valid <= 1'b1;
                wr_rsp_mdata <= wr_pend_mdata[wr_pick];
                wr_pend_mdata.delete(wr_pick);
                wr_pend_due.delete(wr_pick);
            end
            // New requests always wait at least one cycle
            if (rd_req_valid)
            begin
                rd_pend_mdata.push_back(rd_req_mdata);
                rd_pend_data.push_back(mem_word(rd_req_addr));
                rd_pend_due.push_back(cycle + pick_delay());
            end
            if (wr_req_valid)
            begin
                wr_pend_mdata.push_back(wr_req_mdata);
                wr_pend_due.push_back(cycle + pick_delay());
            end
        end
    end

endmodule

/* verif/rsp_order_tb.sv */
// Self-checking testbench that expects reads back in issue order and each write mdata back once
module rsp_order_tb
    import rsp_order_pkg::*;
();

    // ==============================
    // Run parameters
    // ==============================

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int SEQ_LEN = 200;
    localparam int MIXED_LEN = 200;

    // Every request of every test with back-pressure taken at full buffer depth
    localparam int TOTAL_REQS = 1 + 2 * SEQ_LEN + 2 * MAX_ACTIVE_REQS + 2 * MIXED_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 + 1000;

    logic clk;
    logic reset;
    logic afu_rd_req_valid;
    t_addr afu_rd_req_addr;
    t_mdata afu_rd_req_mdata;
    logic fiu_rd_req_valid;
    t_addr fiu_rd_req_addr;
    t_mdata fiu_rd_req_mdata;
    logic afu_wr_req_valid;
    t_addr afu_wr_req_addr;
    t_data afu_wr_req_data;
    t_mdata afu_wr_req_mdata;
    logic fiu_wr_req_valid;
    t_addr fiu_wr_req_addr;
    t_data fiu_wr_req_data;
    t_mdata fiu_wr_req_mdata;
    logic fiu_rd_rsp_valid;
    t_mdata fiu_rd_rsp_mdata;
    t_data fiu_rd_rsp_data;
    logic fiu_wr_rsp_valid;
    t_mdata fiu_wr_rsp_mdata;
    logic afu_rd_rsp_valid;
    t_mdata afu_rd_rsp_mdata;
    t_data afu_rd_rsp_data;
    logic afu_wr_rsp_valid;
    t_mdata afu_wr_rsp_mdata;
    logic fiu_rd_almost_full;
    logic fiu_wr_almost_full;
    logic afu_rd_almost_full;
    logic afu_wr_almost_full;

    // Fabric controls
    logic hold_rsp;
    logic raise_rd_af;
    logic raise_wr_af;

    integer seed = 32'h02fa05ea;
    string test_name = "none";

    // The checker walks the reads in issue order with its own pointer
    t_addr rd_exp_addr [$];
    t_mdata rd_exp_mdata [$];
    int rd_chk_ptr = 0;

    // Outstanding writes are those issued but not yet returned
    bit wr_issued [t_mdata];
    bit wr_returned [t_mdata];
    int wr_ret_cnt = 0;

    // Last write request put on the AFU side, which the fabric side must show in the same cycle
    logic wr_drv_valid = 1'b0;
    t_addr wr_drv_addr;
    t_data wr_drv_data;

    int chk_errors = 0;
    int stim_errors = 0;
    int err_base = 0;
    int pass_count = 0;
    int fail_count = 0;

    rsp_order_shim DUT (.*);

    fiu_model fabric (
        .clk, .reset, .hold_rsp, .raise_rd_af, .raise_wr_af,
        .rd_req_valid(fiu_rd_req_valid),
        .rd_req_addr(fiu_rd_req_addr),
        .rd_req_mdata(fiu_rd_req_mdata),
        .wr_req_valid(fiu_wr_req_valid),
        .wr_req_mdata(fiu_wr_req_mdata),
        .rd_rsp_valid(fiu_rd_rsp_valid),
        .rd_rsp_mdata(fiu_rd_rsp_mdata),
        .rd_rsp_data(fiu_rd_rsp_data),
        .wr_rsp_valid(fiu_wr_rsp_valid),
        .wr_rsp_mdata(fiu_wr_rsp_mdata),
        .rd_almost_full(fiu_rd_almost_full),
        .wr_almost_full(fiu_wr_almost_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Reference and helpers
    // ==============================

    // The fabric memory holds address xor 5ac3 in the upper half and address plus 0f1d below
    function automatic t_data expected_read(input t_addr addr);
        return {addr ^ 16'h5ac3, addr + 16'h0f1d};
    endfunction

    function automatic bit roll(input int pct);
        return int'(($random(seed) & 32'h7fffffff) % 100) < pct;
    endfunction

    task automatic show_mismatch(input string what, input t_data exp, input t_data act);
        $display("[ERROR] %s: %s expected 0x%h, actual 0x%h", test_name, what, exp, act);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base = chk_errors + stim_errors;
    endtask

    task automatic end_test();
        if (chk_errors + stim_errors == err_base)
        begin
            pass_count++;
            $display("Test %s passed", test_name);
        end
        else
        begin
            fail_count++;
            $display("Test %s failed with %0d errors", test_name,
                     chk_errors + stim_errors - err_base);
        end
    endtask

    // Called right after a rising edge to record what each new request should return
    task automatic drive_cycle(input bit rd_en, input bit wr_en);
        t_addr addr;
        t_mdata mdata;
        t_data data;
        addr = t_addr'($random(seed));
        mdata = t_mdata'($random(seed));
        afu_rd_req_valid <= rd_en;
        if (rd_en)
        begin
            afu_rd_req_addr <= addr;
            afu_rd_req_mdata <= mdata;
            rd_exp_addr.push_back(addr);
            rd_exp_mdata.push_back(mdata);
        end
        afu_wr_req_valid <= wr_en;
        wr_drv_valid <= wr_en;
        if (wr_en)
        begin
            // Write tags are unique over the whole run
            while (wr_issued.exists(mdata))
            begin
                mdata = t_mdata'($random(seed));
            end
            wr_issued[mdata] = 1'b1;
            data = t_data'($random(seed));
            afu_wr_req_addr <= addr;
            afu_wr_req_data <= data;
            afu_wr_req_mdata <= mdata;
            wr_drv_addr <= addr;
            wr_drv_data <= data;
        end
    endtask

    // Idle a few cycles past the last answer so stray responses are caught
    task automatic wait_drain();
        while (rd_chk_ptr != rd_exp_addr.size() || wr_ret_cnt != wr_issued.num())
        begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
    endtask

    // Almost-full is sampled at the edge, so each new request obeys it
    task automatic run_traffic(input int n_rd, input int n_wr, input int rd_pct, input int wr_pct);
        int rd_left;
        int wr_left;
        bit rd_en;
        bit wr_en;
        rd_left = n_rd;
        wr_left = n_wr;
        while (rd_left > 0 || wr_left > 0)
        begin
            @(posedge clk);
            rd_en = rd_left > 0 && !afu_rd_almost_full && roll(rd_pct);
            wr_en = wr_left > 0 && !afu_wr_almost_full && roll(wr_pct);
            drive_cycle(rd_en, wr_en);
            rd_left -= int'(rd_en);
            wr_left -= int'(wr_en);
        end
        @(posedge clk);
        drive_cycle(1'b0, 1'b0);
        wait_drain();
    endtask

    // Issue on one channel until almost-full shows, then use up the slack.
    // The request on the bus in the cycle almost-full was seen counts as one of them
    task automatic fill_until_full(input bit on_rd);
        while (on_rd ? !afu_rd_almost_full : !afu_wr_almost_full)
        begin
            drive_cycle(on_rd, !on_rd);
            @(posedge clk);
        end
        repeat (ALMOST_FULL_SLACK - 1)
        begin
            drive_cycle(on_rd, !on_rd);
            @(posedge clk);
        end
        drive_cycle(1'b0, 1'b0);
        @(posedge clk);
    endtask

    // ==============================
    // Comparison process
    // ==============================

    always @(posedge clk)
    begin
        if (!reset && afu_rd_rsp_valid)
        begin
            if (rd_chk_ptr >= rd_exp_addr.size())
            begin
                $display("Read response arrived in %s with no read outstanding", test_name);
                chk_errors++;
            end
            else
            begin
                if (afu_rd_rsp_mdata !== rd_exp_mdata[rd_chk_ptr])
                begin
                    show_mismatch("read mdata", t_data'(rd_exp_mdata[rd_chk_ptr]),
                                  t_data'(afu_rd_rsp_mdata));
                    chk_errors++;
                end
                if (afu_rd_rsp_data !== expected_read(rd_exp_addr[rd_chk_ptr]))
                begin
                    show_mismatch("read data", expected_read(rd_exp_addr[rd_chk_ptr]),
                                  afu_rd_rsp_data);
                    chk_errors++;
                end
                rd_chk_ptr++;
            end
        end
        if (!reset && afu_wr_rsp_valid)
        begin
            if (!wr_issued.exists(afu_wr_rsp_mdata) || wr_returned.exists(afu_wr_rsp_mdata))
            begin
                $display("Write response in %s carries mdata 0x%h, which is not outstanding",
                         test_name, afu_wr_rsp_mdata);
                chk_errors++;
            end
            else
            begin
                wr_returned[afu_wr_rsp_mdata] = 1'b1;
                wr_ret_cnt++;
            end
        end

        // Write requests reach the fabric in the cycle they are issued, with address and data intact
        if (!reset && fiu_wr_req_valid !== wr_drv_valid)
        begin
            show_mismatch("write request valid", t_data'(wr_drv_valid),
                          t_data'(fiu_wr_req_valid));
            chk_errors++;
        end
        if (!reset && wr_drv_valid)
        begin
            if (fiu_wr_req_addr !== wr_drv_addr)
            begin
                show_mismatch("write request addr", t_data'(wr_drv_addr),
                              t_data'(fiu_wr_req_addr));
                chk_errors++;
            end
            if (fiu_wr_req_data !== wr_drv_data)
            begin
                show_mismatch("write request data", wr_drv_data, fiu_wr_req_data);
                chk_errors++;
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin
        reset = 1'b1;
        afu_rd_req_valid = 1'b0;
        afu_rd_req_addr = '0;
        afu_rd_req_mdata = '0;
        afu_wr_req_valid = 1'b0;
        afu_wr_req_addr = '0;
        afu_wr_req_data = '0;
        afu_wr_req_mdata = '0;
        hold_rsp = 1'b0;
        raise_rd_af = 1'b0;
        raise_wr_af = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        begin_test("after_reset");
        repeat (2) @(posedge clk);
        if (afu_rd_rsp_valid !== 1'b0)
        begin
            show_mismatch("afu_rd_rsp_valid", 0, t_data'(afu_rd_rsp_valid));
            stim_errors++;
        end
        if (afu_wr_rsp_valid !== 1'b0)
        begin
            show_mismatch("afu_wr_rsp_valid", 0, t_data'(afu_wr_rsp_valid));
            stim_errors++;
        end
        if (afu_rd_almost_full !== 1'b0 || afu_wr_almost_full !== 1'b0)
        begin
            show_mismatch("almost-full pair", 0,
                          t_data'({afu_rd_almost_full, afu_wr_almost_full}));
            stim_errors++;
        end
        end_test();

        begin_test("single_read");
        run_traffic(1, 0, 100, 0);
        end_test();

        begin_test("read_order");
        run_traffic(SEQ_LEN, 0, 100, 0);
        end_test();

        begin_test("write_return");
        run_traffic(0, SEQ_LEN, 0, 100);
        end_test();

        // Fabric stays silent while both buffers fill to the limit
        begin_test("back_pressure");
        @(posedge clk);
        hold_rsp <= 1'b1;
        fill_until_full(1'b1);
        fill_until_full(1'b0);
        repeat (20) @(posedge clk);
        hold_rsp <= 1'b0;
        wait_drain();
        end_test();

        begin_test("almost_full_mixed");
        @(posedge clk);
        raise_rd_af <= 1'b1;
        @(posedge clk);
        if (afu_rd_almost_full !== 1'b1 || afu_wr_almost_full !== 1'b0)
        begin
            show_mismatch("rd/wr almost-full", 2,
                          t_data'({afu_rd_almost_full, afu_wr_almost_full}));
            stim_errors++;
        end
        raise_rd_af <= 1'b0;
        raise_wr_af <= 1'b1;
        @(posedge clk);
        if (afu_rd_almost_full !== 1'b0 || afu_wr_almost_full !== 1'b1)
        begin
            show_mismatch("rd/wr almost-full", 1,
                          t_data'({afu_rd_almost_full, afu_wr_almost_full}));
            stim_errors++;
        end
        raise_wr_af <= 1'b0;
        run_traffic(MIXED_LEN, MIXED_LEN, 60, 60);
        end_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Ends a run whose responses never arrive
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out in %s after %0d cycles", test_name, WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* verilog.f */
verilog/rsp_order_pkg.sv
verilog/slot_ram.sv
verilog/wr_mdata_heap.sv
verilog/rd_reorder_buffer.sv
verilog/rsp_order_shim.sv
verif/fiu_model.sv
verif/rsp_order_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the response-ordering shim testbench with Verilator.
# The run counts as passing only if the log holds the pass message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    -f verilog.f \
    --top-module rsp_order_tb \
    -Mdir obj_dir \
    -o rsp_order_sim

./obj_dir/rsp_order_sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
